// File: rv32.f
+incdir+hdl
+incdir+bench
hdl/rv32_pkg.sv
hdl/rv32_fetch.sv
hdl/rv32_decode.sv
hdl/rv32_execute.sv
hdl/rv32_mem.sv
hdl/rv32.sv
bench/rv32_tb.sv

// File: build.sh
#!/bin/sh
# Builds the rv32 testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary -f rv32.f --top-module rv32_tb -o rv32_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/rv32_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: bench/rv32_model.svh
`ifndef RV32_MODEL_SVH
`define RV32_MODEL_SVH

localparam int MAX_INSTRS = 60;
localparam int PROLOGUE = 13;
localparam logic [11:0] DATA_BASE = 12'h200; // 16 bytes of data live here.

logic [31:0] lcg_state;
logic [31:0] prog [MAX_INSTRS];
int prog_len;
writeback_t expected_q[$];

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// value in 0 .. n-1, taken from the better high bits.
function automatic int pick(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'({8'd0, r[31:8]}) % n;
endfunction

// sources come from x0..x8 and x31, never the previous load's rd.
function automatic logic [4:0] src_reg(logic [4:0] avoid);
    int n;
    logic [4:0] r;
    do begin
        n = pick(10);
        r = (n < 9) ? 5'(n) : 5'd31;
    end while (avoid != 5'd0 && r == avoid);
    return r;
endfunction

// destinations skip x1 and x2, which hold the data base and the auipc result.
function automatic logic [4:0] dst_reg();
    int n;
    n = pick(7);
    return (n < 6) ? 5'(n + 3) : 5'd31;
endfunction

function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function automatic void generate_program();
    int kind;
    int k;
    int w;
    logic [31:0] r;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] load_rd;
    logic [4:0] next_load_rd;
    logic [11:0] imm;
    prog_len = 40 + pick(MAX_INSTRS - 39);
    prog[0] = i_type(DATA_BASE, 5'd0, 3'd0, 5'd1, 7'h13);
    prog[1] = {20'd0, 5'd2, 7'h17}; // auipc x2, 0 so x2 = 4.
    for (int j = 0; j < 7; j++) begin
        r = lcg_next();
        prog[2 + j] = i_type(r[31:20], 5'd0, 3'd0, (j < 6) ? 5'(j + 3) : 5'd31, 7'h13);
    end
    for (int j = 0; j < 4; j++) begin
        prog[9 + j] = s_type(12'(4 * j), 5'(j + 3), 5'd1, 3'd2); // fill the data region.
    end
    load_rd = 5'd0;
    for (int i = PROLOGUE; i < prog_len - 1; i++) begin
        kind = pick(10);
        k = 2 + pick(7);
        if (k > prog_len - 1 - i) k = prog_len - 1 - i;
        if (kind >= 8 && k < 2) kind = pick(8); // too close to the end for a jump.
        next_load_rd = 5'd0;
        r = lcg_next();
        f3 = r[14:12];
        rd = dst_reg();
        case (kind)
            0, 1, 2: begin
                prog[i] = r_type((f3 == 3'd0 || f3 == 3'd5) && r[30] ? 7'h20 : 7'h00,
                                 src_reg(load_rd), src_reg(load_rd), f3, rd);
            end
            3, 4: begin
                imm = r[31:20];
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, r[30] && f3 == 3'd5, 5'd0, r[24:20]};
                prog[i] = i_type(imm, src_reg(load_rd), f3, rd, 7'h13);
            end
            5: prog[i] = {r[31:12], rd, r[5] ? 7'h37 : 7'h17}; // lui or auipc.
            6: begin
                w = pick(3);
                prog[i] = s_type(12'(pick(16 >> w) << w), src_reg(load_rd), 5'd1, 3'(w));
            end
            7: begin
                w = pick(3);
                f3 = {w < 2 && r[7], 2'(w)};
                prog[i] = i_type(12'(pick(16 >> w) << w), 5'd1, f3, rd, 7'h03);
                next_load_rd = rd;
            end
            8: begin
                w = pick(6);
                f3 = (w < 2) ? 3'(w) : 3'(w + 2);
                prog[i] = b_type(13'(k * 4), src_reg(load_rd), src_reg(load_rd), f3);
            end
            default: begin
                if (r[9]) prog[i] = j_type(21'(k * 4), rd);
                else prog[i] = i_type(12'((i + k) * 4 - 4), 5'd2, 3'd0, rd, 7'h67);
            end
        endcase
        load_rd = next_load_rd;
    end
    prog[prog_len - 1] = j_type(21'd0, 5'd0); // park on a jump to itself.
endfunction

function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
    logic [31:0] y;
    case (f3)
        3'd0: y = alt ? a - b : a + b;
        3'd1: y = a << b[4:0];
        3'd2: y = {31'd0, $signed(a) < $signed(b)};
        3'd3: y = {31'd0, a < b};
        3'd4: y = a ^ b;
        3'd5: begin
            // kept apart so the arithmetic shift stays signed.
            if (alt) begin
                y = $signed(a) >>> b[4:0];
            end else begin
                y = a >> b[4:0];
            end
        end
        3'd6: y = a | b;
        default: y = a & b;
    endcase
    return y;
endfunction

// ISA-level run of prog, queueing every write to a nonzero rd in order.
function automatic void run_model();
    logic [31:0] x [32];
    logic [7:0] mem [16];
    logic [31:0] pc, next_pc, ins, a, b, imm_i, imm_s, val;
    logic [3:0] at;
    logic [2:0] f3;
    logic [4:0] rd;
    logic write;
    logic taken;
    for (int j = 0; j < 32; j++) x[j] = 32'd0;
    for (int j = 0; j < 16; j++) mem[j] = 8'd0;
    expected_q.delete();
    pc = 32'd0;
    for (int n = 0; n < MAX_INSTRS; n++) begin
        ins = prog[pc[7:2]];
        rd = ins[11:7];
        f3 = ins[14:12];
        a = x[ins[19:15]];
        b = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        next_pc = pc + 32'd4;
        write = 1'b1;
        val = 32'd0;
        case (ins[6:0])
            7'h37: val = {ins[31:12], 12'd0};
            7'h17: val = pc + {ins[31:12], 12'd0};
            7'h6f: begin
                val = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                val = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                write = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h03: begin
                at = a[3:0] + imm_i[3:0]; // the region is 16 bytes, aligned.
                case (f3)
                    3'd0: val = {{24{mem[at][7]}}, mem[at]};
                    3'd1: val = {{16{mem[at + 4'd1][7]}}, mem[at + 4'd1], mem[at]};
                    3'd4: val = {24'd0, mem[at]};
                    3'd5: val = {16'd0, mem[at + 4'd1], mem[at]};
                    default: val = {mem[at + 4'd3], mem[at + 4'd2], mem[at + 4'd1], mem[at]};
                endcase
            end
            7'h23: begin
                write = 1'b0;
                at = a[3:0] + imm_s[3:0];
                mem[at] = b[7:0];
                if (f3 != 3'd0) mem[at + 4'd1] = b[15:8];
                if (f3 == 3'd2) begin
                    mem[at + 4'd2] = b[23:16];
                    mem[at + 4'd3] = b[31:24];
                end
            end
            7'h13: val = alu(f3, ins[30] && f3 == 3'd5, a, imm_i);
            7'h33: val = alu(f3, ins[30], a, b);
            default: write = 1'b0;
        endcase
        if (write && rd != 5'd0) begin
            x[rd] = val;
            expected_q.push_back(writeback_t'({1'b1, rd, val}));
        end
        if (next_pc == pc) break; // reached the final self loop.
        pc = next_pc;
    end
endfunction

`endif

// File: bench/rv32_tb.sv
`timescale 1ns/1ps

`include "rv32_consts.svh"

module rv32_tb import rv32_pkg::*; ();

    localparam int NUM_PROGRAMS = 40;
    localparam int CYCLE_LIMIT = NUM_PROGRAMS * (60 * 5 + 40);
    localparam int IDLE_CYCLES = 20;

    logic clk;
    logic reset;
    imem_write_t imem_load;
    logic [7:0] leds;
    writeback_t retire;

    logic [7:0] led_model; // low byte of the latest x31 write.
    int prog_num;
    int cycles = 0;

`include "rv32_model.svh"

    rv32 dut0 (
        .clk(clk),
        .reset(reset),
        .imem_load(imem_load),
        .leds(leds),
        .retire(retire)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, program %0d never finished", cycles, prog_num);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // wait for the falling edge and check what the DUT shows there.
    task automatic step();
        writeback_t head;
        @(negedge clk);
        if (reset) begin
            compare("retire during reset", 32'd0, {31'd0, retire.writeback});
            compare("leds during reset", 32'd0, {24'd0, leds});
        end else begin
            compare($sformatf("program %0d leds", prog_num), {24'd0, led_model}, {24'd0, leds});
            if (retire.writeback && retire.rd != 5'd0) begin
                if (expected_q.size() == 0) begin
                    // nothing pending, so no nonzero rd may retire.
                    compare($sformatf("program %0d extra retire rd", prog_num),
                            32'd0, {27'd0, retire.rd});
                end else begin
                    head = expected_q.pop_front();
                    compare($sformatf("program %0d retire rd", prog_num),
                            {27'd0, head.rd}, {27'd0, retire.rd});
                    compare($sformatf("program %0d retire value x%0d", prog_num, head.rd),
                            head.value, retire.value);
                    if (head.rd == `RV32_LED_REG) led_model = head.value[7:0];
                end
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        imem_load = '0;
        led_model = 8'd0;
        lcg_state = 32'h356949f1;
        for (prog_num = 0; prog_num < NUM_PROGRAMS; prog_num++) begin
            generate_program();
            run_model();
            reset = 1'b1;
            led_model = 8'd0;
            // a few nops behind the program cover the fetches past its end.
            for (int i = 0; i < prog_len + 4; i++) begin
                step();
                imem_load.en = 1'b1;
                imem_load.addr = i[7:0];
                imem_load.data = (i < prog_len) ? prog[i] : `RV32_NOP;
            end
            step();
            imem_load = '0;
            repeat (2) step();
            reset = 1'b0;
            step();
            compare("retire after reset", 32'd0, {31'd0, retire.writeback});
            compare("leds after reset", 32'd0, {24'd0, leds});
            while (expected_q.size() != 0) begin
                step();
            end
            repeat (IDLE_CYCLES) step();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hdl/rv32.sv
`timescale 1ns/1ps

`include "rv32_consts.svh"

module rv32 import rv32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  imem_write_t imem_load,
    output logic [7:0]  leds,
    output writeback_t  retire
);

    fetch_out_t fetch_out;
    decode_out_t decode_out;
    execute_out_t execute_out;
    writeback_t writeback;
    branch_t branch;

    rv32_fetch fetch0 (
        .clk(clk),
        .reset(reset),
        .imem_load(imem_load),
        .branch(branch),
        .fetch_out(fetch_out)
    );

    rv32_decode decode0 (
        .clk(clk),
        .reset(reset),
        .fetch_out(fetch_out),
        .writeback(writeback), // register file write port.
        .branch(branch),
        .decode_out(decode_out)
    );

    rv32_execute execute0 (
        .clk(clk),
        .reset(reset),
        .decode_out(decode_out),
        .writeback(writeback), // forwarding source.
        .branch(branch),
        .execute_out(execute_out)
    );

    rv32_mem mem0 (
        .clk(clk),
        .reset(reset),
        .execute_out(execute_out),
        .writeback(writeback),
        .branch(branch)
    );

    assign retire = writeback;

    // leds mirror the low byte of each write to the led register.
    always_ff @(posedge clk) begin
        if (reset) begin
            leds <= 8'd0;
        end else if (writeback.writeback && writeback.rd == `RV32_LED_REG) begin
            leds <= writeback.value[7:0];
        end
    end

endmodule

// File: hdl/rv32_mem.sv
`timescale 1ns/1ps

`include "rv32_consts.svh"

module rv32_mem import rv32_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  execute_out_t execute_out,
    output writeback_t   writeback,
    output branch_t      branch
);

    localparam int DMEM_AW = $clog2(`RV32_DMEM_WORDS);

    logic [31:0] dmem [`RV32_DMEM_WORDS];

    logic [DMEM_AW-1:0] addr;
    logic [1:0] offset;
    logic [3:0] strobe;
    logic [31:0] store_data;
    logic [31:0] word;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    logic [31:0] load_value;
    logic result_zero;

    assign addr   = execute_out.result[DMEM_AW+1:2];
    assign offset = execute_out.result[1:0];
    assign word   = dmem[addr];

    // place the store data on every lane, the strobe picks the lanes.
    always_comb begin
        case (execute_out.mem_width)
            WIDTH_BYTE: begin
                strobe     = 4'b0001 << offset;
                store_data = {4{execute_out.rs2_value[7:0]}};
            end
            WIDTH_HALF: begin
                strobe     = offset[1] ? 4'b1100 : 4'b0011;
                store_data = {2{execute_out.rs2_value[15:0]}};
            end
            default: begin
                strobe     = 4'b1111;
                store_data = execute_out.rs2_value;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (execute_out.valid && execute_out.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (strobe[i]) dmem[addr][8*i +: 8] <= store_data[8*i +: 8];
            end
        end
    end

    assign load_byte = word[{offset, 3'b000} +: 8];
    assign load_half = word[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (execute_out.mem_width)
            WIDTH_BYTE: load_value = {{24{!execute_out.zero_extend && load_byte[7]}}, load_byte};
            WIDTH_HALF: load_value = {{16{!execute_out.zero_extend && load_half[15]}}, load_half};
            default:    load_value = word;
        endcase
    end

    always_ff @(posedge clk) begin
        writeback.writeback <= !reset && execute_out.valid && execute_out.rd_writeback;
        writeback.rd        <= execute_out.rd;
        writeback.value     <= execute_out.mem_read ? load_value : execute_out.result;
    end

    assign result_zero = execute_out.result == 32'd0;

    // resolved here, so fetch, decode and execute squash together.
    assign branch.taken = execute_out.valid &&
                          (execute_out.branch_op == BRANCH_ALWAYS ||
                           (execute_out.branch_op == BRANCH_ZERO && result_zero) ||
                           (execute_out.branch_op == BRANCH_NONZERO && !result_zero));
    assign branch.pc = execute_out.branch_pc;

endmodule

// File: hdl/rv32_execute.sv
`timescale 1ns/1ps

module rv32_execute import rv32_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  decode_out_t  decode_out,
    input  writeback_t   writeback,
    input  branch_t      branch,
    output execute_out_t execute_out
);

    logic [31:0] rs1_value, rs2_value;
    logic [31:0] op1, op2;
    logic [31:0] result;
    logic [31:0] branch_base;
    logic [31:0] branch_pc;
    logic own_fwd_ok;

    // load data is not ready in our own register, only on writeback.
    assign own_fwd_ok = execute_out.valid && execute_out.rd_writeback &&
                        !execute_out.mem_read && execute_out.rd != 5'd0;

    function automatic logic [31:0] forward(logic [4:0] rs, logic [31:0] decoded);
        logic [31:0] value;
        if (own_fwd_ok && execute_out.rd == rs) begin
            value = execute_out.result;
        end else if (writeback.writeback && writeback.rd != 5'd0 && writeback.rd == rs) begin
            value = writeback.value;
        end else begin
            value = decoded;
        end
        return value;
    endfunction

    assign rs1_value = forward(decode_out.rs1, decode_out.rs1_value);
    assign rs2_value = forward(decode_out.rs2, decode_out.rs2_value);

    always_comb begin
        case (decode_out.src1)
            SRC1_RS1: op1 = rs1_value;
            SRC1_PC:  op1 = decode_out.pc;
            default:  op1 = 32'd0;
        endcase
        case (decode_out.src2)
            SRC2_RS2: op2 = rs2_value;
            SRC2_IMM: op2 = decode_out.imm;
            default:  op2 = 32'd4;
        endcase
    end

    always_comb begin
        case (decode_out.alu_op)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_SLL:  result = op1 << op2[4:0];
            ALU_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {31'd0, op1 < op2};
            ALU_XOR:  result = op1 ^ op2;
            ALU_SRL:  result = op1 >> op2[4:0];
            ALU_SRA:  result = $signed(op1) >>> op2[4:0];
            ALU_OR:   result = op1 | op2;
            default:  result = op1 & op2;
        endcase
    end

    // jalr uses rs1 as the base, everything else the pc.
    assign branch_base = decode_out.branch_pc_src ? rs1_value : decode_out.pc;
    assign branch_pc   = (branch_base + decode_out.imm) & ~32'd1;

    always_ff @(posedge clk) begin
        execute_out.valid        <= decode_out.valid && !(reset || branch.taken);
        execute_out.mem_read     <= decode_out.mem_read;
        execute_out.mem_write    <= decode_out.mem_write;
        execute_out.mem_width    <= decode_out.mem_width;
        execute_out.zero_extend  <= decode_out.zero_extend;
        execute_out.branch_op    <= decode_out.branch_op;
        execute_out.rd           <= decode_out.rd;
        execute_out.rd_writeback <= decode_out.rd_writeback;
        execute_out.result       <= result;
        execute_out.rs2_value    <= rs2_value; // store data.
        execute_out.branch_pc    <= branch_pc;
    end

endmodule

// File: hdl/rv32_decode.sv
`timescale 1ns/1ps

module rv32_decode import rv32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fetch_out_t  fetch_out,
    input  writeback_t  writeback,
    input  branch_t     branch,
    output decode_out_t decode_out
);

    // major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    logic [31:0] regs [1:31];

    logic [31:0] instr;
    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    decode_out_t next;

    assign instr  = fetch_out.instr;
    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // a register being written this cycle is seen by the read.
    function automatic logic [31:0] read_reg(logic [4:0] idx);
        logic [31:0] value;
        if (idx == 5'd0) begin
            value = 32'd0;
        end else if (writeback.writeback && writeback.rd == idx) begin
            value = writeback.value;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // shared by register and immediate alu ops.
    function automatic alu_op_t alu_from_funct3(logic [2:0] f3, logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        next.valid         = fetch_out.valid;
        next.rs1           = instr[19:15];
        next.rs2           = instr[24:20];
        next.rd            = instr[11:7];
        next.alu_op        = ALU_ADD;
        next.src1          = SRC1_RS1;
        next.src2          = SRC2_IMM;
        next.mem_read      = 1'b0;
        next.mem_write     = 1'b0;
        next.mem_width     = mem_width_t'(funct3[1:0]);
        next.zero_extend   = funct3[2];
        next.branch_op     = BRANCH_NEVER;
        next.branch_pc_src = 1'b0;
        next.rd_writeback  = 1'b0;
        next.pc            = fetch_out.pc;
        next.rs1_value     = read_reg(instr[19:15]);
        next.rs2_value     = read_reg(instr[24:20]);
        next.imm           = imm_i;

        case (opcode)
            OP_LUI: begin
                next.src1         = SRC1_ZERO;
                next.imm          = imm_u;
                next.rd_writeback = 1'b1;
            end
            OP_AUIPC: begin
                next.src1         = SRC1_PC;
                next.imm          = imm_u;
                next.rd_writeback = 1'b1;
            end
            OP_JAL: begin
                next.src1         = SRC1_PC; // link value is pc + 4.
                next.src2         = SRC2_FOUR;
                next.imm          = imm_j;
                next.branch_op    = BRANCH_ALWAYS;
                next.rd_writeback = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    next.src1          = SRC1_PC;
                    next.src2          = SRC2_FOUR;
                    next.branch_op     = BRANCH_ALWAYS;
                    next.branch_pc_src = 1'b1;
                    next.rd_writeback  = 1'b1;
                end
            end
            OP_BRANCH: begin
                next.src2 = SRC2_RS2;
                next.imm  = imm_b;
                if (funct3[2:1] != 2'b01) begin
                    // eq/ne compare via xor, lt/ge via slt or sltu.
                    case (funct3[2:1])
                        2'b00:   next.alu_op = ALU_XOR;
                        2'b10:   next.alu_op = ALU_SLT;
                        default: next.alu_op = ALU_SLTU;
                    endcase
                    next.branch_op = (funct3[0] ^ funct3[2]) ? BRANCH_NONZERO : BRANCH_ZERO;
                end
            end
            OP_LOAD: begin
                if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
                    next.mem_read     = 1'b1;
                    next.rd_writeback = 1'b1;
                end
            end
            OP_STORE: begin
                next.imm = imm_s;
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                    next.mem_write = 1'b1;
                end
            end
            OP_IMM: begin
                next.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
                if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0000000 ||
                    (funct3 == 3'b101 && funct7 == 7'b0100000)) begin
                    next.rd_writeback = 1'b1;
                end
            end
            OP_REG: begin
                next.src2   = SRC2_RS2;
                next.alu_op = alu_from_funct3(funct3, funct7[5]);
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    next.rd_writeback = 1'b1;
                end
            end
            default: begin
                // unknown encoding, retires as a no-op.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (writeback.writeback && writeback.rd != 5'd0) begin
            regs[writeback.rd] <= writeback.value;
        end
    end

    always_ff @(posedge clk) begin
        decode_out <= next;
        if (reset || branch.taken) begin
            decode_out.valid <= 1'b0; // bubble.
        end
    end

endmodule

// File: hdl/rv32_fetch.sv
`timescale 1ns/1ps

`include "rv32_consts.svh"

module rv32_fetch import rv32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  imem_write_t imem_load,
    input  branch_t     branch,
    output fetch_out_t  fetch_out
);

    localparam int IMEM_AW = $clog2(`RV32_IMEM_WORDS);

    logic [31:0] imem [`RV32_IMEM_WORDS];
    logic [31:0] pc;
    logic squash;

    assign squash = reset || branch.taken;

    // program load port, used while the core is held in reset.
    always_ff @(posedge clk) begin
        if (imem_load.en) begin
            imem[imem_load.addr] <= imem_load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV32_RESET_PC;
        end else if (branch.taken) begin
            pc <= branch.pc; // redirect from mem stage.
        end else begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        fetch_out.valid <= !squash;
        fetch_out.pc    <= pc;
        if (squash) begin
            fetch_out.instr <= `RV32_NOP;
        end else begin
            fetch_out.instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

// File: hdl/rv32_pkg.sv
package rv32_pkg;

`include "rv32_consts.svh"

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_t;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_t;

    // branch ops test the alu result.
    typedef enum logic [1:0] {
        BRANCH_NEVER,
        BRANCH_ALWAYS,
        BRANCH_ZERO,
        BRANCH_NONZERO
    } branch_op_t;

    // matches funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD} mem_width_t;

    typedef struct packed {
        logic en;
        logic [$clog2(`RV32_IMEM_WORDS)-1:0] addr; // word index.
        logic [31:0] data;
    } imem_write_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_out_t;

    typedef struct packed {
        logic valid;
        logic [4:0] rs1;
        logic [4:0] rs2;
        alu_op_t alu_op;
        src1_t src1;
        src2_t src2;
        logic mem_read;
        logic mem_write;
        mem_width_t mem_width;
        logic zero_extend;
        branch_op_t branch_op;
        logic branch_pc_src; // 1 selects rs1, 0 selects pc.
        logic [4:0] rd;
        logic rd_writeback;
        logic [31:0] pc;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm;
    } decode_out_t;

    typedef struct packed {
        logic valid;
        logic mem_read;
        logic mem_write;
        mem_width_t mem_width;
        logic zero_extend;
        branch_op_t branch_op;
        logic [4:0] rd;
        logic rd_writeback;
        logic [31:0] result;
        logic [31:0] rs2_value;
        logic [31:0] branch_pc;
    } execute_out_t;

    typedef struct packed {
        logic writeback;
        logic [4:0] rd;
        logic [31:0] value;
    } writeback_t;

    typedef struct packed {
        logic taken;
        logic [31:0] pc;
    } branch_t;

endpackage

// File: hdl/rv32_consts.svh
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// instruction memory depth in 32-bit words.
`define RV32_IMEM_WORDS 256

// data memory depth in 32-bit words.
`define RV32_DMEM_WORDS 256

// first instruction fetched after reset.
`define RV32_RESET_PC 32'h0000_0000

// writes to this register are mirrored on the leds.
`define RV32_LED_REG 5'd31

// addi x0, x0, 0.
`define RV32_NOP 32'h0000_0013

`endif
